// File: sim.f
+incdir+hw
hw/z80Pkg.sv
hw/addHlDecoder.sv
hw/addHlSequencer.sv
hw/regPairFile.sv
hw/byteAlu.sv
hw/addHlCore.sv
bench/addHlCore_assert.sv
bench/addHlCore_tb.sv

// File: Makefile
# Verilator build and run for the ADD HL,ss / LD rr,nn slice.
VERILATOR ?= verilator
TOP       ?= addHlCore_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list is newer than the binary
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q '^RESULT: PASS$$' $(LOG)

check: run
	@echo "simulation passed, log in $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/addHl_tests.txt
# opcode imm result flags(c n h) busy: hex, hex, hex, binary, binary
# busy 1 pulses a second start while the ADD is still running
01 0001 0001 000 0
11 0F0F 0F0F 000 0
21 12FF 12FF 000 0
31 FFFF FFFF 000 0
09 0000 1300 000 0
19 0000 220F 001 0
39 0000 220E 101 0
00 0000 220E 101 0
C9 ABCD 220E 101 0
29 0000 441C 000 0
39 0000 441B 101 0
11 8000 8000 101 0
19 0000 C41B 000 0
76 0000 C41B 000 0
09 0000 C41C 000 0
19 0000 441C 100 1
39 0000 441B 101 0
21 FFFF FFFF 101 0
29 0000 FFFE 101 0
41 5555 FFFE 101 0

// File: bench/addHlCore_tb.sv
// Vectors come from bench/addHl_tests.txt, read relative to the project root.
// A busy start is only meaningful on ADD lines, which run long enough to be hit.
`timescale 1ns/1ps
`default_nettype none
`include "z80_defines.svh"

module addHlCore_tb;

    import z80Pkg::*;

    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 10;
    localparam int    NUM_RANDOM   = 24;
    localparam string TEST_FILE    = "bench/addHl_tests.txt";

    typedef struct packed {
        logic [`Z80_BYTE_W-1:0] op;
        logic [`Z80_WORD_W-1:0] imm;
        logic [`Z80_WORD_W-1:0] result;
        flags_t                 flags;
        logic                   busy;     // second start during the instruction.
        logic                   fromFile; // carries its own expected values.
    } testVec_t;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   start;
    logic [`Z80_BYTE_W-1:0] opcode;
    logic [`Z80_WORD_W-1:0] imm;
    logic                   done;
    logic [`Z80_WORD_W-1:0] result;
    flags_t                 flags;

    testVec_t               tests[$];
    logic [`Z80_WORD_W-1:0] modelPairs[4];
    flags_t                 modelFlags;
    logic                   testsLoaded = 1'b0;

    addHlCore i_addHlCore (.*);

    bind addHlSequencer addHlCore_assert i_addHlCore_assert (
        .clk(clk), .rst(rst), .state(state), .opClass(opClass), .uop(uop), .done(done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int unsigned assertFailCount();
        return i_addHlCore.i_addHlSequencer.i_addHlCore_assert.failCount;
    endfunction

    // ##################################################
    // reporting
    // ##################################################
    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input logic [`Z80_WORD_W-1:0] got,
                             input logic [`Z80_WORD_W-1:0] exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf("Error at time %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkFlags(input flags_t got, input flags_t exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf("Error at time %0t: %s are c=%b n=%b h=%b, expected c=%b n=%b h=%b",
                $time, what, got.c, got.n, got.h, exp.c, exp.n, exp.h));
        end
    endtask

    // a failed sequencer assertion ends the run at the next falling edge.
    always @(negedge clk) begin
        if (assertFailCount() != 0) begin
            stopRun("a sequencer assertion failed");
        end
    end

    // ##################################################
    // reference model
    // ##################################################
    task automatic modelExecute(input logic [7:0] op, input logic [15:0] immVal,
                                output logic [15:0] expResult, output flags_t expFlags);
        logic [16:0] wide;
        logic [12:0] low12;
        logic [15:0] srcVal;
        if (op[7:6] == 2'b00 && op[3:0] == 4'b0001) begin
            modelPairs[op[5:4]] = immVal;
            expResult = immVal;
        end else if (op[7:6] == 2'b00 && op[3:0] == 4'b1001) begin
            srcVal = modelPairs[op[5:4]];
            wide   = {1'b0, modelPairs[RP_HL]} + {1'b0, srcVal};
            low12  = {1'b0, modelPairs[RP_HL][11:0]} + {1'b0, srcVal[11:0]};
            modelPairs[RP_HL] = wide[15:0];
            modelFlags.c = wide[16];     // carry out of bit 15.
            modelFlags.n = 1'b0;
            modelFlags.h = low12[12];    // carry out of bit 11.
            expResult = wide[15:0];
        end else begin
            expResult = modelPairs[RP_HL]; // no-op shows HL.
        end
        expFlags = modelFlags;
    endtask

    task automatic loadTests();
        int          fd;
        int          n;
        int          lineNo;
        string       line;
        testVec_t    v;
        logic [7:0]  op;
        logic [15:0] immVal;
        logic [15:0] res;
        logic [2:0]  f;
        logic        busy;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            stopRun($sformatf("could not open the test file %s", TEST_FILE));
        end
        lineNo = 0;
        while ($fgets(line, fd) != 0) begin
            lineNo++;
            if (line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %b %b", op, immVal, res, f, busy);
            if (n == 5) begin
                v = '0;
                v.op       = op;
                v.imm      = immVal;
                v.result   = res;
                v.flags    = flags_t'(f);
                v.busy     = busy;
                v.fromFile = 1'b1;
                tests.push_back(v);
            end else if (n > 0) begin
                stopRun($sformatf("line %0d of the test file has missing columns", lineNo));
            end
        end
        $fclose(fd);
    endtask

    task automatic addRandomTests();
        logic [31:0] seed;
        testVec_t    v;
        seed = 32'd82;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            seed = lcgNext(seed);
            v = '0;
            // mostly ADD HL,ss with a fresh load now and then.
            v.op = {2'b00, seed[21:20], (seed[23:22] == 2'b00) ? 4'b0001 : 4'b1001};
            seed = lcgNext(seed);
            v.imm = seed[31:16];
            tests.push_back(v);
        end
    endtask

    // ##################################################
    // one instruction
    // ##################################################
    task automatic runTest(input testVec_t v, input int idx);
        logic [`Z80_WORD_W-1:0] expResult;
        flags_t                 expFlags;
        modelExecute(v.op, v.imm, expResult, expFlags);
        if (v.fromFile) begin
            checkWord(v.result, expResult, $sformatf("file result of test %0d vs model", idx));
            checkFlags(v.flags, expFlags, $sformatf("file flags of test %0d vs model", idx));
        end
        @(posedge clk);
        start  <= 1'b1;
        opcode <= v.op;
        imm    <= v.imm;
        @(posedge clk);
        start <= 1'b0;
        if (v.busy) begin
            @(posedge clk);
            start  <= 1'b1;      // sampled while the ADD sits in S_LOW.
            opcode <= 8'h31;
            imm    <= 16'hDEAD;
            @(posedge clk);
            start <= 1'b0;
        end
        @(negedge clk);
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        @(negedge clk);
        checkWord(result, expResult, $sformatf("result of test %0d (opcode %h)", idx, v.op));
        checkFlags(flags, expFlags, $sformatf("flags of test %0d (opcode %h)", idx, v.op));
    endtask

    initial begin
        rst    <= 1'b1;
        start  <= 1'b0;
        opcode <= '0;
        imm    <= '0;
        for (int i = 0; i < 4; i++) begin
            modelPairs[i] = '0;
        end
        modelFlags = '0;
        loadTests();
        addRandomTests();
        testsLoaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        foreach (tests[i]) begin
            runTest(tests[i], i);
        end
        if (assertFailCount() != 0) begin
            stopRun("a sequencer assertion failed");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

    // watchdog, ten cycles per instruction plus reset.
    initial begin
        wait (testsLoaded === 1'b1);
        #((tests.size() * 10 + RESET_CYCLES + 2) * CLK_PERIOD);
        stopRun($sformatf("timeout: %0d instructions did not finish in time", tests.size()));
    end

endmodule

`default_nettype wire

// File: bench/addHlCore_assert.sv
// Concurrent checks on the sequencer; bound into addHlSequencer by the testbench.
`timescale 1ns/1ps
`default_nettype none

module addHlCore_assert (
    input wire logic              clk,
    input wire logic              rst,
    input wire z80Pkg::seqState_e state,
    input wire z80Pkg::opClass_e  opClass,
    input wire z80Pkg::microOp_t  uop,
    input wire logic              done
);

    import z80Pkg::*;

    logic        anyStrobe;
    int unsigned failCount = 0; // read by the testbench.

    assign anyStrobe = uop.writeL || uop.writeH || uop.loadImm || uop.aluLow || uop.aluHigh;

    donePulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            failCount++;
            $error("done stayed high for two cycles");
        end

    idleQuiet: assert property (@(posedge clk) disable iff (rst) (state == S_IDLE) |-> !anyStrobe)
        else begin
            failCount++;
            $error("micro-op strobe active in S_IDLE");
        end

    // the high byte step must follow the low byte step of an add.
    addSteps: assert property (@(posedge clk) disable iff (rst)
        (state == S_LOW && opClass == OP_ADD_HL) |=> (state == S_HIGH))
        else begin
            failCount++;
            $error("S_LOW of ADD HL,ss not followed by S_HIGH");
        end

endmodule

`default_nettype wire

// File: hw/addHlCore.sv
// Top of the pair slice; result and flags are valid the cycle after done.
`timescale 1ns/1ps
`default_nettype none
`include "z80_defines.svh"

module addHlCore (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   start,
    input  wire logic [`Z80_BYTE_W-1:0] opcode,
    input  wire logic [`Z80_WORD_W-1:0] imm,
    output logic                        done,
    output logic [`Z80_WORD_W-1:0]      result,
    output z80Pkg::flags_t              flags
);

    import z80Pkg::*;

    logic [`Z80_BYTE_W-1:0] latchedOpcode;
    logic [`Z80_WORD_W-1:0] latchedImm;
    opClass_e               opClass;
    regPair_e               pair;
    microOp_t               uop;
    logic [`Z80_WORD_W-1:0] hlLane;
    logic [`Z80_WORD_W-1:0] srcLane;
    aluOut_t                aluOut;

    addHlDecoder i_addHlDecoder (
        .opcode  (latchedOpcode),
        .opClass (opClass),
        .pair    (pair)
    );

    addHlSequencer i_addHlSequencer (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .opcode        (opcode),
        .imm           (imm),
        .opClass       (opClass),
        .pair          (pair),
        .latchedOpcode (latchedOpcode),
        .latchedImm    (latchedImm),
        .uop           (uop),
        .done          (done)
    );

    regPairFile i_regPairFile (
        .clk    (clk),
        .rst    (rst),
        .uop    (uop),
        .aluSum (aluOut.sum),
        .imm    (latchedImm),
        .hl     (hlLane),
        .src    (srcLane),
        .dest   (result)
    );

    // operand bytes sit in the low lane.
    byteAlu i_byteAlu (
        .clk (clk),
        .rst (rst),
        .uop (uop),
        .a   (hlLane[`Z80_BYTE_W-1:0]),
        .b   (srcLane[`Z80_BYTE_W-1:0]),
        .out (aluOut)
    );

    assign flags = aluOut.flags;

endmodule

`default_nettype wire

// File: hw/byteAlu.sv
// Byte adder for the two-step 16-bit add; only C, N and H are produced.
`timescale 1ns/1ps
`default_nettype none
`include "z80_defines.svh"

module byteAlu (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire z80Pkg::microOp_t       uop,
    input  wire logic [`Z80_BYTE_W-1:0] a,
    input  wire logic [`Z80_BYTE_W-1:0] b,
    output z80Pkg::aluOut_t             out
);

    import z80Pkg::*;

    logic                 cin;
    logic                 carryLatch;
    logic [`Z80_BYTE_W:0] sumWide;
    logic [4:0]           nibSum;
    flags_t               flagReg;

    // ##################################################
    // adder
    // ##################################################
    assign cin     = uop.aluHigh ? carryLatch : 1'b0;
    assign sumWide = {1'b0, a} + {1'b0, b} + {{`Z80_BYTE_W{1'b0}}, cin};
    assign nibSum  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0, cin}; // half carry.

    always_ff @(posedge clk) begin
        if (rst) begin
            carryLatch <= 1'b0;
            flagReg    <= '0;
        end else begin
            if (uop.aluLow) begin
                carryLatch <= sumWide[`Z80_BYTE_W]; // carry into the high byte.
            end
            if (uop.aluHigh) begin
                flagReg.c <= sumWide[`Z80_BYTE_W]; // word bit 15.
                flagReg.h <= nibSum[4];            // word bit 11.
                flagReg.n <= 1'b0;
            end
        end
    end

    assign out.sum   = sumWide[`Z80_BYTE_W-1:0];
    assign out.flags = flagReg;

endmodule

`default_nettype wire

// File: hw/regPairFile.sv
// hl and src present the byte lane of the current ALU step in bits 7:0.
// ALU results always go to HL; immediates go to uop.dest.
`timescale 1ns/1ps
`default_nettype none
`include "z80_defines.svh"

module regPairFile (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire z80Pkg::microOp_t       uop,
    input  wire logic [`Z80_BYTE_W-1:0] aluSum,
    input  wire logic [`Z80_WORD_W-1:0] imm,
    output logic [`Z80_WORD_W-1:0]      hl,
    output logic [`Z80_WORD_W-1:0]      src,
    output logic [`Z80_WORD_W-1:0]      dest
);

    import z80Pkg::*;

    logic [`Z80_WORD_W-1:0] pairs [4];
    regPair_e               wrSel;
    logic [`Z80_BYTE_W-1:0] wrLow;
    logic [`Z80_BYTE_W-1:0] wrHigh;
    logic [`Z80_WORD_W-1:0] hlWord;
    logic [`Z80_WORD_W-1:0] srcWord;

    // ##################################################
    // write port
    // ##################################################
    assign wrSel  = uop.loadImm ? uop.dest : RP_HL;
    assign wrLow  = uop.loadImm ? imm[7:0] : aluSum;
    assign wrHigh = uop.loadImm ? imm[15:8] : aluSum;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                pairs[i] <= '0;
            end
        end else begin
            if (uop.writeL) begin
                pairs[wrSel][7:0] <= wrLow;
            end
            if (uop.writeH) begin
                pairs[wrSel][15:8] <= wrHigh;
            end
        end
    end

    // ##################################################
    // read ports
    // ##################################################
    assign hlWord  = pairs[RP_HL];
    assign srcWord = pairs[uop.dest];

    // high step swaps the lanes so the ALU always reads bits 7:0.
    assign hl  = uop.aluHigh ? {hlWord[7:0], hlWord[15:8]} : hlWord;
    assign src = uop.aluHigh ? {srcWord[7:0], srcWord[15:8]} : srcWord;

    assign dest = pairs[uop.dest];

endmodule

`default_nettype wire

// File: hw/addHlSequencer.sv
// One instruction at a time; start is ignored outside S_IDLE.
// uop.dest keeps pointing at the last result pair while idle.
`timescale 1ns/1ps
`default_nettype none
`include "z80_defines.svh"

module addHlSequencer (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   start,
    input  wire logic [`Z80_BYTE_W-1:0] opcode,
    input  wire logic [`Z80_WORD_W-1:0] imm,
    input  wire z80Pkg::opClass_e       opClass,
    input  wire z80Pkg::regPair_e       pair,
    output logic [`Z80_BYTE_W-1:0]      latchedOpcode,
    output logic [`Z80_WORD_W-1:0]      latchedImm,
    output z80Pkg::microOp_t            uop,
    output logic                        done
);

    import z80Pkg::*;

    seqState_e state;
    seqState_e nextState;

    // ##################################################
    // state and instruction latches
    // ##################################################
    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= S_IDLE;
            latchedOpcode <= '0;
        end else begin
            state <= nextState;
            if (state == S_IDLE && start) begin
                latchedOpcode <= opcode;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            latchedImm <= imm;
        end
    end

    always_comb begin
        case (state)
            S_IDLE:   nextState = start ? S_DECODE : S_IDLE;
            S_DECODE: nextState = (opClass == OP_NONE) ? S_IDLE : S_LOW;
            S_LOW:    nextState = (opClass == OP_ADD_HL) ? S_HIGH : S_IDLE;
            default:  nextState = S_IDLE;
        endcase
    end

    // ##################################################
    // micro-op strobes
    // ##################################################
    always_comb begin
        uop      = '0;
        uop.dest = (opClass == OP_LD_RR) ? pair : RP_HL; // result view when idle.
        case (state)
            S_LOW: begin
                uop.dest   = pair;
                uop.writeL = 1'b1;
                if (opClass == OP_LD_RR) begin
                    uop.writeH  = 1'b1;
                    uop.loadImm = 1'b1;
                end else begin
                    uop.aluLow = 1'b1;
                end
            end
            S_HIGH: begin
                uop.dest    = pair;
                uop.writeH  = 1'b1;
                uop.aluHigh = 1'b1;
            end
            default: ;
        endcase
    end

    assign done = (state == S_HIGH)
               || (state == S_LOW && opClass == OP_LD_RR)
               || (state == S_DECODE && opClass == OP_NONE);

endmodule

`default_nettype wire

// File: hw/addHlDecoder.sv
// Decodes only LD rr,nn and ADD HL,ss; every other opcode is OP_NONE.
`timescale 1ns/1ps
`default_nettype none
`include "z80_defines.svh"

module addHlDecoder (
    input  wire logic [`Z80_BYTE_W-1:0] opcode,
    output z80Pkg::opClass_e            opClass,
    output z80Pkg::regPair_e            pair
);

    import z80Pkg::*;

    logic topMatch;
    logic isLd;
    logic isAdd;

    // ##################################################
    // pattern match
    // ##################################################
    assign topMatch = (opcode[7:6] == `Z80_OP_TOP);
    assign isLd     = topMatch && (opcode[3:0] == `Z80_OP_LD_RR);
    assign isAdd    = topMatch && (opcode[3:0] == `Z80_OP_ADD_HL);

    always_comb begin
        if (isAdd) begin
            opClass = OP_ADD_HL;
        end else if (isLd) begin
            opClass = OP_LD_RR;
        end else begin
            opClass = OP_NONE;
        end
    end

    // ss field, BC/DE/HL/SP.
    assign pair = regPair_e'(opcode[5:4]);

endmodule

`default_nettype wire

// File: hw/z80Pkg.sv
// Shared types for the 16-bit pair execution slice.
// Only the C, N and H flags are modelled.
`default_nettype none

package z80Pkg;

`include "z80_defines.svh"

    typedef enum logic [1:0] {
        OP_NONE,
        OP_LD_RR,
        OP_ADD_HL
    } opClass_e;

    // same order as the ss field.
    typedef enum logic [1:0] {
        RP_BC,
        RP_DE,
        RP_HL,
        RP_SP
    } regPair_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_DECODE,
        S_LOW,
        S_HIGH
    } seqState_e;

    typedef struct packed {
        logic     writeL;   // write low byte of target pair.
        logic     writeH;   // write high byte of target pair.
        logic     loadImm;  // immediate is the write source.
        logic     aluLow;   // low byte add, carry in 0.
        logic     aluHigh;  // high byte add with latched carry.
        regPair_e dest;
    } microOp_t;

    typedef struct packed {
        logic c;
        logic n;
        logic h;
    } flags_t;

    typedef struct packed {
        logic [`Z80_BYTE_W-1:0] sum;
        flags_t                 flags;
    } aluOut_t;

endpackage

`default_nettype wire

// File: hw/z80_defines.svh
// Width and opcode macros for the ADD HL,ss / LD rr,nn slice.
// Opcode patterns cover only the 00ss_xxxx block of the unprefixed map.
`ifndef Z80_DEFINES_SVH
`define Z80_DEFINES_SVH

`define Z80_BYTE_W 8
`define Z80_WORD_W 16

// ##################################################
// opcode fields
// ##################################################
`define Z80_OP_TOP    2'b00     // bits 7:6 of both instructions.
`define Z80_OP_LD_RR  4'b0001   // LD rr,nn low nibble.
`define Z80_OP_ADD_HL 4'b1001   // ADD HL,ss low nibble.

`endif
